//--- stream_pkg.sv
/*
 * Shared definitions for the stream buffer: beat widths, FIFO sizing,
 * the beat and flag structs and the vector types used on every port.
 * Modules import this package in their body and use scoped names in
 * their port lists.
 */

package stream_pkg;

  // ----------------------------------------------------------
  // Beat format
  // ----------------------------------------------------------
  localparam int DATA_WIDTH = 32;                // Payload bits per beat
  localparam int STRB_WIDTH = DATA_WIDTH / 8;    // One enable per byte

  // ----------------------------------------------------------
  // FIFO sizing
  // ----------------------------------------------------------
  localparam int FIFO_DEPTH      = 8;            // Storage entries
  localparam int FIFO_ADDR_WIDTH = 3;            // log2 of depth
  // Entries left free when push ready drops; matches the beats
  // still in flight through the registered ingress path
  localparam int STALL_SLOTS     = 2;

  // ----------------------------------------------------------
  // Egress statistics
  // ----------------------------------------------------------
  localparam int CNT_WIDTH = 16;                 // Wrapping beat counter

  // Vector types with a meaning
  typedef logic [DATA_WIDTH-1:0]      data_t;      // Beat data
  typedef logic [STRB_WIDTH-1:0]      strb_t;      // Byte enables
  typedef logic [CNT_WIDTH-1:0]       beat_cnt_t;  // Delivered beats
  typedef logic [FIFO_ADDR_WIDTH-1:0] fifo_ptr_t;  // Read/write pointer

  // One stream beat, data in the upper bits
  typedef struct packed {
    data_t data;
    strb_t strb;
  } stream_beat_t;

  // FIFO status as seen from outside
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_flags_t;

endpackage

//--- stream_ingress.sv
/*
 * Input register stage of the stream buffer. Registers the producer beat
 * and also the ready shown to the producer, so in_ready_o lags the FIFO's
 * push ready by one cycle. The FIFO keeps slots free for that lag.
 */

`timescale 1ns/1ps

module stream_ingress (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   clear_i,       // Sync flush
  input  logic                   in_valid_i,
  input  stream_pkg::stream_beat_t in_beat_i,
  input  logic                   push_ready_i,  // From FIFO, early stall
  output logic                   in_ready_o,
  output logic                   push_valid_o,
  output stream_pkg::stream_beat_t push_beat_o
);

  import stream_pkg::*;

  logic         ready_q;   // Delayed push ready
  logic         valid_q;   // Beat register holds a live beat
  stream_beat_t beat_q;    // Beat payload

  // ----------------------------------------------------------
  // Control state
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ready_q <= 1'b0;                    // Producer sees ready low out of reset
      valid_q <= 1'b0;
    end else if (clear_i) begin
      ready_q <= 1'b0;                    // Same result as reset
      valid_q <= 1'b0;
    end else begin
      ready_q <= push_ready_i;            // One cycle late by design
      valid_q <= in_valid_i & ready_q;    // Handshake seen by the producer
    end
  end

  // ----------------------------------------------------------
  // Payload register
  // ----------------------------------------------------------
  // Loaded every cycle; the FIFO never refuses a valid beat, so there
  // is no hold path. Stale data is harmless while valid_q is low.
  always_ff @(posedge clk_i) begin
    beat_q <= in_beat_i;
  end

  assign in_ready_o   = ready_q;
  assign push_valid_o = valid_q;
  assign push_beat_o  = beat_q;

endmodule

//--- stream_fifo_earlystall.sv
/*
 * Circular-buffer FIFO with an early push stall. Push ready falls while
 * STALL_SLOTS entries are still free, so beats already in flight from a
 * registered upstream stage are always written. A state machine over
 * EMPTY, MIDDLE and FULL tracks occupancy; clear_i flushes synchronously.
 */

`timescale 1ns/1ps

module stream_fifo_earlystall (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,      // Sync flush that drops contents
  input  logic                     push_valid_i,
  input  stream_pkg::stream_beat_t push_beat_i,
  input  logic                     pop_ready_i,
  output logic                     push_ready_o, // Early-stall ready
  output logic                     pop_valid_o,
  output stream_pkg::stream_beat_t pop_beat_o,   // Zero while not valid
  output stream_pkg::fifo_flags_t  flags_o
);

  import stream_pkg::*;

  typedef enum logic [1:0] {
    EMPTY,
    MIDDLE,
    FULL
  } fifo_state_e;

  fifo_state_e state_q, state_d;

  fifo_ptr_t wr_ptr_q, wr_ptr_d;            // Next slot to write
  fifo_ptr_t rd_ptr_q, rd_ptr_d;            // Oldest stored entry
  fifo_ptr_t wr_ptr_inc, rd_ptr_inc;        // Pointers after one step

  logic [FIFO_ADDR_WIDTH:0] fill_cnt;       // Entries stored, 0..FIFO_DEPTH

  logic push_en;                            // Beat written this cycle
  logic pop_en;                             // Beat leaves this cycle

  stream_beat_t mem [FIFO_DEPTH];           // Beat storage

  // Step a pointer, wrapping after the last entry
  function automatic fifo_ptr_t ptr_step(fifo_ptr_t ptr);
    fifo_ptr_t nxt;
    if (ptr == fifo_ptr_t'(FIFO_DEPTH - 1)) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  assign wr_ptr_inc = ptr_step(wr_ptr_q);
  assign rd_ptr_inc = ptr_step(rd_ptr_q);

  // ----------------------------------------------------------
  // Occupancy and handshakes
  // ----------------------------------------------------------
  always_comb begin
    if (state_q == FULL) begin
      fill_cnt = (FIFO_ADDR_WIDTH+1)'(FIFO_DEPTH);     // Pointers equal and all slots used
    end else if (wr_ptr_q >= rd_ptr_q) begin
      fill_cnt = {1'b0, wr_ptr_q} - {1'b0, rd_ptr_q};
    end else begin
      fill_cnt = (FIFO_ADDR_WIDTH+1)'(FIFO_DEPTH)      // Write pointer wrapped
               - {1'b0, rd_ptr_q} + {1'b0, wr_ptr_q};
    end
  end

  // Drop ready with STALL_SLOTS entries still free
  assign push_ready_o = (fill_cnt < (FIFO_ADDR_WIDTH+1)'(FIFO_DEPTH - STALL_SLOTS));

  assign pop_valid_o = (state_q != EMPTY);
  assign pop_en      = pop_valid_o & pop_ready_i;

  // Early stall keeps room for every beat in flight
  assign push_en = push_valid_i;

  // ----------------------------------------------------------
  // Next state and pointers
  // ----------------------------------------------------------
  always_comb begin
    state_d  = state_q;
    wr_ptr_d = push_en ? wr_ptr_inc : wr_ptr_q;
    rd_ptr_d = pop_en  ? rd_ptr_inc : rd_ptr_q;

    case (state_q)
      EMPTY: begin
        if (push_en) begin
          state_d = MIDDLE;                 // First beat stored
        end
      end
      MIDDLE: begin
        if (push_en && !pop_en && (wr_ptr_inc == rd_ptr_q)) begin
          state_d = FULL;                   // Write closes the gap
        end else if (pop_en && !push_en && (rd_ptr_inc == wr_ptr_q)) begin
          state_d = EMPTY;                  // Last beat read
        end
      end
      FULL: begin
        if (pop_en && !push_en) begin
          state_d = MIDDLE;
        end
      end
      default: begin
        state_d  = EMPTY;                   // Recover from illegal encoding
        wr_ptr_d = '0;
        rd_ptr_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= EMPTY;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else if (clear_i) begin
      state_q  <= EMPTY;                    // Contents discarded
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      state_q  <= state_d;
      wr_ptr_q <= wr_ptr_d;
      rd_ptr_q <= rd_ptr_d;
    end
  end

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (push_en) begin
      mem[wr_ptr_q] <= push_beat_i;
    end
  end

  assign pop_beat_o = pop_valid_o ? mem[rd_ptr_q] : '0;  // Hide stale entries

  // Status straight from the state
  assign flags_o.empty = (state_q == EMPTY);
  assign flags_o.full  = (state_q == FULL);

endmodule

//--- stream_egress.sv
/*
 * Output register of the stream buffer. Holds one beat toward the
 * consumer, zeroes every data byte whose strobe bit is clear as the beat
 * is loaded, and counts delivered beats in a wrapping counter.
 */

`timescale 1ns/1ps

module stream_egress (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,     // Sync flush, also zeroes count
  input  logic                     pop_valid_i,
  input  stream_pkg::stream_beat_t pop_beat_i,
  input  logic                     out_ready_i,
  output logic                     pop_ready_o,
  output logic                     out_valid_o,
  output stream_pkg::stream_beat_t out_beat_o,
  output stream_pkg::beat_cnt_t    beat_cnt_o
);

  import stream_pkg::*;

  logic         valid_q;     // Register holds a beat
  stream_beat_t beat_q;      // Masked beat toward consumer
  beat_cnt_t    cnt_q;       // Delivered beats since reset/clear
  logic         load;        // Take a beat from the FIFO
  logic         deliver;     // Consumer handshake

  // Clear data bytes with a low strobe, strobe passes unchanged
  function automatic stream_beat_t mask_beat(stream_beat_t beat);
    stream_beat_t masked;
    masked = beat;
    for (int b = 0; b < STRB_WIDTH; b++) begin
      if (!beat.strb[b]) begin
        masked.data[8*b +: 8] = 8'h00;
      end
    end
    return masked;
  endfunction

  assign pop_ready_o = ~valid_q | out_ready_i;   // Empty or draining
  assign load        = pop_valid_i & pop_ready_o;
  assign deliver     = valid_q & out_ready_i;

  // ----------------------------------------------------------
  // Control and counter
  // ----------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else if (clear_i) begin
      valid_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      if (load) begin
        valid_q <= 1'b1;                 // Refill, possibly back to back
      end else if (out_ready_i) begin
        valid_q <= 1'b0;
      end
      if (deliver) begin
        cnt_q <= cnt_q + 1'b1;           // Wraps at CNT_WIDTH
      end
    end
  end

  // Payload only moves on a load
  always_ff @(posedge clk_i) begin
    if (load) begin
      beat_q <= mask_beat(pop_beat_i);
    end
  end

  assign out_valid_o = valid_q;
  assign out_beat_o  = beat_q;
  assign beat_cnt_o  = cnt_q;

endmodule

//--- stream_buffer_top.sv
/*
 * Top level of the stream buffer: ingress register, early-stall FIFO and
 * egress register in a chain. Exposes the FIFO flags and the count of
 * beats delivered to the consumer.
 */

`timescale 1ns/1ps

module stream_buffer_top (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     clear_i,      // Flushes all three stages
  input  logic                     in_valid_i,
  input  stream_pkg::stream_beat_t in_beat_i,
  output logic                     in_ready_o,
  output logic                     out_valid_o,
  output stream_pkg::stream_beat_t out_beat_o,
  input  logic                     out_ready_i,
  output stream_pkg::fifo_flags_t  flags_o,
  output stream_pkg::beat_cnt_t    beat_cnt_o
);

  import stream_pkg::*;

  // ----------------------------------------------------------
  // Inter-stage streams
  // ----------------------------------------------------------
  logic         push_valid;   // Ingress to FIFO
  logic         push_ready;   // Early stall, registered by ingress
  stream_beat_t push_beat;
  logic         pop_valid;    // FIFO to egress
  logic         pop_ready;
  stream_beat_t pop_beat;

  stream_ingress i_ingress (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .in_valid_i   (in_valid_i),
    .in_beat_i    (in_beat_i),
    .push_ready_i (push_ready),
    .in_ready_o   (in_ready_o),
    .push_valid_o (push_valid),
    .push_beat_o  (push_beat)
  );

  stream_fifo_earlystall i_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .push_valid_i (push_valid),
    .push_beat_i  (push_beat),
    .pop_ready_i  (pop_ready),
    .push_ready_o (push_ready),
    .pop_valid_o  (pop_valid),
    .pop_beat_o   (pop_beat),
    .flags_o      (flags_o)      // Reported as is
  );

  stream_egress i_egress (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .clear_i      (clear_i),
    .pop_valid_i  (pop_valid),
    .pop_beat_i   (pop_beat),
    .out_ready_i  (out_ready_i),
    .pop_ready_o  (pop_ready),
    .out_valid_o  (out_valid_o),
    .out_beat_o   (out_beat_o),
    .beat_cnt_o   (beat_cnt_o)
  );

endmodule

//--- stream_buffer_tb.sv
/*
 * Testbench for the stream buffer. Runs a table of phases with different
 * consumer ready patterns against a reference queue of masked beats and
 * checks order, masking, stall capacity, latency, count, flags and clear.
 */

`timescale 1ns/1ps

module stream_buffer_tb;

  import stream_pkg::*;

  typedef enum logic [1:0] {RDY_ALWAYS, RDY_NEVER, RDY_RANDOM} rdy_mode_e;

  typedef struct {
    int        n_beats;     // Beats offered in the phase
    rdy_mode_e mode;        // Consumer ready pattern
    bit        clear_end;   // Pulse clear_i when the phase ends
    int        exp_accept;  // Beats the buffer must take
  } phase_t;

  localparam int NUM_PHASES = 7;
  localparam int STALL_WAIT = 8;    // Low-ready cycles that count as a stall

  logic         clk_i;
  logic         rst_ni;
  logic         clear_i;
  logic         in_valid_i;
  stream_beat_t in_beat_i;
  logic         in_ready_o;
  logic         out_valid_o;
  stream_beat_t out_beat_o;
  logic         out_ready_i;
  fifo_flags_t  flags_o;
  beat_cnt_t    beat_cnt_o;

  phase_t       phases [NUM_PHASES];
  stream_beat_t ref_q [$];          // Expected beats with masking applied
  beat_cnt_t    delivered;          // Transfers seen at the output
  bit           last_taken;         // Producer may offer a new beat
  int           cycle_cnt = 0;
  int           cycle_limit;

  stream_buffer_top DUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .clear_i     (clear_i),
    .in_valid_i  (in_valid_i),
    .in_beat_i   (in_beat_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_beat_o  (out_beat_o),
    .out_ready_i (out_ready_i),
    .flags_o     (flags_o),
    .beat_cnt_o  (beat_cnt_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;                 // 20 ns period
  end

  // ------------------------------------------------------------
  // Reporting
  // ------------------------------------------------------------
  task automatic abort_run();
    $display("FAIL: see errors above");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: %s is 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      abort_run();
    end
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  // ------------------------------------------------------------
  // Beat helpers
  // ------------------------------------------------------------
  // Bytes with a clear strobe bit read as zero at the output
  function automatic stream_beat_t expected_beat(stream_beat_t b);
    stream_beat_t e;
    data_t        keep;
    keep   = {{8{b.strb[3]}}, {8{b.strb[2]}}, {8{b.strb[1]}}, {8{b.strb[0]}}};
    e.data = b.data & keep;
    e.strb = b.strb;
    return e;
  endfunction

  function automatic stream_beat_t random_beat();
    stream_beat_t b;
    b.data = $urandom;
    b.strb = strb_t'($urandom_range(0, 15));
    return b;
  endfunction

  // ------------------------------------------------------------
  // Directed sequences entered 2 ns after a rising edge
  // ------------------------------------------------------------
  task automatic measure_latency();
    stream_beat_t beat;
    int           edges;
    beat        = random_beat();
    in_beat_i   = beat;
    in_valid_i  = 1'b1;
    out_ready_i = 1'b1;
    @(negedge clk_i);
    check_value("in_ready_o", in_ready_o, 1);   // Empty buffer takes it
    @(posedge clk_i);                           // Accepting edge
    #2;
    in_valid_i = 1'b0;
    last_taken = 1'b1;
    edges      = 0;
    do begin
      @(posedge clk_i);
      edges++;
      @(negedge clk_i);
    end while (!out_valid_o);
    check_value("latency in cycles", edges, 2);
    check_value("out_beat_o", out_beat_o, expected_beat(beat));
    delivered++;                                // Taken at the next edge
    @(posedge clk_i);
    #2;
  endtask

  task automatic pulse_clear();
    clear_i     = 1'b1;
    in_valid_i  = 1'b0;                         // Stream is flushed anyway
    out_ready_i = 1'b0;
    last_taken  = 1'b1;
    @(posedge clk_i);
    #2;
    clear_i = 1'b0;
    @(negedge clk_i);
    check_value("out_valid_o", out_valid_o, 0);
    check_value("flags_o.empty", flags_o.empty, 1);
    check_value("beat_cnt_o", beat_cnt_o, 0);
    check_value("in_ready_o", in_ready_o, 0);   // Same as after reset
    ref_q.delete();
    delivered = '0;
    @(posedge clk_i);
    #2;
  endtask

  task automatic verify_phase_end(phase_t p, int accepted);
    check_value("accepted beats", accepted, p.exp_accept);
    if (p.mode == RDY_NEVER) begin
      check_value("in_ready_o", in_ready_o, 0);
      check_value("flags_o.full", flags_o.full, 1);
      check_value("out_valid_o", out_valid_o, 1);
    end else begin
      check_value("flags_o.empty", flags_o.empty, 1);
      check_value("beat_cnt_o", beat_cnt_o, delivered);
    end
  endtask

  // Offer one table row of beats and watch both handshakes until drained
  task automatic run_phase(phase_t p);
    int accepted;
    int stall;
    bit done;
    accepted = 0;
    stall    = 0;
    done     = 1'b0;
    while (!done) begin
      if (last_taken || !in_valid_i) begin      // Held beat stays until taken
        in_valid_i = (accepted < p.n_beats) &&
                     ((p.mode != RDY_RANDOM) || ($urandom_range(0, 1) == 1));
        in_beat_i  = random_beat();
      end
      case (p.mode)
        RDY_ALWAYS: out_ready_i = 1'b1;
        RDY_NEVER:  out_ready_i = 1'b0;
        default:    out_ready_i = ($urandom_range(0, 1) == 1);
      endcase
      @(negedge clk_i);
      check_value("beat_cnt_o", beat_cnt_o, delivered);
      last_taken = in_valid_i && in_ready_o;
      if (last_taken) begin
        ref_q.push_back(expected_beat(in_beat_i));
        accepted++;
      end
      if (out_valid_o && out_ready_i) begin
        if (ref_q.size() == 0) begin
          $display("The output delivered a beat that was never accepted");
          abort_run();
        end
        check_value("out_beat_o", out_beat_o, ref_q.pop_front());
        delivered++;
      end
      if (p.mode == RDY_NEVER) begin
        stall = (in_valid_i && !in_ready_o) ? stall + 1 : 0;
        done  = (stall >= STALL_WAIT) || (accepted >= p.n_beats);
      end else begin
        done = (accepted >= p.n_beats) && (ref_q.size() == 0) && !out_valid_o;
      end
      if (done) begin
        verify_phase_end(p, accepted);
      end
      @(posedge clk_i);
      #2;
    end
  endtask

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    void'($urandom(47));
    rst_ni      = 1'b0;
    clear_i     = 1'b0;
    in_valid_i  = 1'b0;
    in_beat_i   = '0;
    out_ready_i = 1'b0;
    delivered   = '0;
    last_taken  = 1'b1;
    // Beats, ready mode, clear at end, beats accepted
    phases[0] = '{20, RDY_ALWAYS, 1'b0, 20};
    phases[1] = '{12, RDY_NEVER,  1'b0, FIFO_DEPTH + 1};   // Stall capacity
    phases[2] = '{16, RDY_ALWAYS, 1'b0, 16};               // Drains the stall
    phases[3] = '{60, RDY_RANDOM, 1'b0, 60};
    phases[4] = '{12, RDY_NEVER,  1'b1, FIFO_DEPTH + 1};   // Clear while stalled
    phases[5] = '{40, RDY_RANDOM, 1'b0, 40};
    phases[6] = '{10, RDY_ALWAYS, 1'b1, 10};
    cycle_limit = 200;
    foreach (phases[i]) cycle_limit += 40 * phases[i].n_beats;

    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("in_ready_o", in_ready_o, 0);
    check_value("out_valid_o", out_valid_o, 0);
    check_value("flags_o.empty", flags_o.empty, 1);
    check_value("flags_o.full", flags_o.full, 0);
    check_value("beat_cnt_o", beat_cnt_o, 0);
    @(posedge clk_i);
    #2;
    @(negedge clk_i);
    check_value("in_ready_o", in_ready_o, 1);   // One cycle after release
    @(posedge clk_i);
    #2;
    measure_latency();

    foreach (phases[i]) begin
      run_phase(phases[i]);
      if (phases[i].clear_end) begin
        pulse_clear();
        measure_latency();                      // Buffer is empty again
      end
    end

    $display("PASS: all tests");
    $finish;
  end

endmodule

//--- build.f
stream_pkg.sv
stream_ingress.sv
stream_fifo_earlystall.sv
stream_egress.sv
stream_buffer_top.sv
stream_buffer_tb.sv

//--- Makefile
# Verilator build and run for the stream buffer testbench

TOP := stream_buffer_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TOP) \
		--Mdir obj_dir -o sim
	@out=$$(./obj_dir/sim 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir
